// File: tb.f
common/kbd_pkg.sv
logic/ps2_line_sync.sv
keyboard/kbd_frame_receiver.sv
keyboard/kbd_scan_decoder.sv
keyboard/kbd_controller.sv
verification/kbd_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the keyboard testbench with Verilator and runs it into sim.log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f tb.f --top-module kbd_tb \
    --Mdir obj_dir -o kbd_sim \
    && ./obj_dir/kbd_sim > "$LOG" 2>&1 \
    || { echo "Build or simulation run failed"; exit 1; }

cat "$LOG"

grep -q "Errors found" "$LOG" \
    && { echo "Simulation FAILED"; exit 1; } \
    || echo "Simulation passed"

exit 0

// File: verification/kbd_tb.sv
`timescale 1ns/1ns
module kbd_tb
import kbd_pkg::*;
;

localparam int half_bit      = 20;     // PS/2 clock half period in core cycles
localparam int event_timeout = 2000;

logic       core_clk;
logic       reset;
ps2_lines_t ps2;
key_event_t key_event;
logic       event_valid;

key_event_t  event_q[$];
logic [31:0] lfsr_state = 32'hce16_1e21;
int          error_count = 0;
int          check_count = 0;

kbd_controller #(
    .timeout_cycles (200)
) i_kbd_controller (
    .core_clk    (core_clk),
    .reset       (reset),
    .ps2         (ps2),
    .key_event   (key_event),
    .event_valid (event_valid)
);

initial begin
    core_clk = 1'b0;
    forever #2 core_clk = ~core_clk;
end

// Strobe is one full cycle wide, so the falling edge sees it exactly once
always @(negedge core_clk) begin
    if (!reset && event_valid) begin
        event_q.push_back(key_event);
    end
end

function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
endfunction

task automatic next_code(output logic [7:0] code);
    do begin
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            code[i]    = lfsr_state[0];
        end
    end while (code == ext_prefix || code == release_prefix);
endtask

task automatic wait_cycles(input int n);
    repeat (n) @(negedge core_clk);
endtask

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
        $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
        error_count++;
    end
endtask

// Frame bits go out LSB first, each set while the PS/2 clock is high
task automatic send_frame(input logic [7:0] code, input logic flip_parity,
                          input logic bad_start, input logic bad_stop,
                          input int num_bits, input int glitch_bit);
    logic        parity;
    logic [10:0] bits;
    parity = ~^code;                   // Odd count of ones over data and parity
    if (flip_parity) begin
        parity = ~parity;
    end
    bits = {~bad_stop, parity, code, bad_start};
    for (int i = 0; i < num_bits; i++) begin
        ps2.data = bits[i];
        wait_cycles(half_bit / 2);
        if (i == glitch_bit) begin
            ps2.clk = 1'b0;            // Short spike on the clock line
            wait_cycles(2);
            ps2.clk = 1'b1;
            wait_cycles(half_bit / 2 - 2);
        end else begin
            wait_cycles(half_bit / 2);
        end
        ps2.clk = 1'b0;
        wait_cycles(half_bit);
        ps2.clk = 1'b1;
    end
    ps2.data = 1'b1;
    wait_cycles(half_bit);
endtask

task automatic send_good(input logic [7:0] code);
    send_frame(code, 1'b0, 1'b0, 1'b0, 11, -1);
endtask

task automatic wait_event(input string name, output key_event_t ev, output logic found);
    int cycles;
    cycles = 0;
    found  = 1'b0;
    while (event_q.size() == 0 && cycles < event_timeout) begin
        @(posedge core_clk);
        cycles++;
    end
    @(negedge core_clk);
    if (event_q.size() == 0) begin
        $display("Timeout in %s: no key event within %0d cycles", name, event_timeout);
        error_count++;
    end else begin
        ev    = event_q.pop_front();
        found = 1'b1;
    end
endtask

task automatic expect_no_event(input string name, input int n);
    int cycles;
    cycles = 0;
    while (event_q.size() == 0 && cycles < n) begin
        @(posedge core_clk);
        cycles++;
    end
    @(negedge core_clk);
    if (event_q.size() != 0) begin
        $display("Unexpected key event in %s: code %h", name, event_q[0].code);
        error_count++;
        event_q.delete();
    end
endtask

task automatic expect_key(input string name, input logic [7:0] code, input logic ext,
                          input logic rel, input logic err);
    key_event_t ev;
    key_event_t exp;
    logic       found;
    wait_event(name, ev, found);
    if (found) begin
        exp.code     = code;
        exp.extended = ext;
        exp.released = rel;
        exp.error    = err;
        check_value(name, {21'd0, exp}, {21'd0, ev});
    end
endtask

task automatic report_test(input string name, input int start_errors);
    if (error_count == start_errors) begin
        $display("Test %s: passed", name);
    end else begin
        $display("Test %s: FAILED with %0d problems", name, error_count - start_errors);
    end
endtask

task automatic test_make_codes();
    int         start;
    logic [7:0] code;
    start = error_count;
    for (int i = 0; i < 20; i++) begin
        next_code(code);
        send_good(code);
        expect_key("make_codes", code, 1'b0, 1'b0, 1'b0);
    end
    report_test("make_codes", start);
endtask

task automatic test_prefixes();
    int         start;
    logic [7:0] code;
    start = error_count;
    next_code(code);
    send_good(release_prefix);
    send_good(code);
    expect_key("prefixes", code, 1'b0, 1'b1, 1'b0);
    next_code(code);
    send_good(ext_prefix);
    send_good(code);
    expect_key("prefixes", code, 1'b1, 1'b0, 1'b0);
    next_code(code);
    send_good(ext_prefix);
    send_good(release_prefix);
    send_good(code);
    expect_key("prefixes", code, 1'b1, 1'b1, 1'b0);
    next_code(code);
    send_good(code);                   // Flags were used up by the last event
    expect_key("prefixes", code, 1'b0, 1'b0, 1'b0);
    report_test("prefixes", start);
endtask

task automatic test_parity_error();
    int         start;
    logic [7:0] code;
    start = error_count;
    next_code(code);
    send_good(ext_prefix);
    send_frame(code, 1'b1, 1'b0, 1'b0, 11, -1);
    expect_key("parity_error", code, 1'b1, 1'b0, 1'b1);
    next_code(code);
    send_good(code);
    expect_key("parity_error", code, 1'b0, 1'b0, 1'b0);
    report_test("parity_error", start);
endtask

task automatic test_framing_errors();
    int         start;
    logic [7:0] code;
    start = error_count;
    next_code(code);
    send_frame(code, 1'b0, 1'b0, 1'b1, 11, -1);     // Stop bit low
    expect_key("framing_errors", code, 1'b0, 1'b0, 1'b1);
    next_code(code);
    send_frame(code, 1'b0, 1'b1, 1'b0, 11, -1);     // Start bit high
    expect_key("framing_errors", code, 1'b0, 1'b0, 1'b1);
    report_test("framing_errors", start);
endtask

task automatic test_stalled_frame();
    int         start;
    logic [7:0] code;
    start = error_count;
    next_code(code);
    send_frame(code, 1'b0, 1'b0, 1'b0, 5, -1);
    expect_no_event("stalled_frame", 400);
    next_code(code);
    send_good(code);
    expect_key("stalled_frame", code, 1'b0, 1'b0, 1'b0);
    report_test("stalled_frame", start);
endtask

task automatic test_glitch();
    int         start;
    logic [7:0] code;
    start = error_count;
    next_code(code);
    send_frame(code, 1'b0, 1'b0, 1'b0, 11, 4);
    expect_key("glitch", code, 1'b0, 1'b0, 1'b0);
    report_test("glitch", start);
endtask

initial begin
    reset    = 1'b1;
    ps2.clk  = 1'b1;                   // Idle bus
    ps2.data = 1'b1;
    repeat (3) @(posedge core_clk);
    @(negedge core_clk);
    reset = 1'b0;
    wait_cycles(10);
    test_make_codes();
    test_prefixes();
    test_parity_error();
    test_framing_errors();
    test_stalled_frame();
    test_glitch();
    $display("Summary: 6 tests, %0d checks, %0d failures", check_count, error_count);
    if (error_count == 0) begin
        $display("No errors");
    end else begin
        $display("Errors found");
    end
    $finish;
end

endmodule

// File: keyboard/kbd_controller.sv
`timescale 1ns/1ns
module kbd_controller
import kbd_pkg::*;
#(
    parameter int sync_stages    = 2,
    parameter int filter_len     = 4,
    parameter int timeout_cycles = 2000
)(
    input  logic       core_clk,
    input  logic       reset,
    input  ps2_lines_t ps2,
    output key_event_t key_event,
    output logic       event_valid
);

logic       line_data;     // Filtered PS/2 data
logic       fall_strobe;   // Filtered PS/2 clock fell
kbd_frame_t frame;
logic       frame_valid;

ps2_line_sync #(
    .sync_stages (sync_stages),
    .filter_len  (filter_len)
) i_ps2_line_sync (
    .core_clk    (core_clk),
    .reset       (reset),
    .ps2         (ps2),
    .data        (line_data),
    .fall_strobe (fall_strobe)
);

kbd_frame_receiver #(
    .timeout_cycles (timeout_cycles)
) i_kbd_frame_receiver (
    .core_clk    (core_clk),
    .reset       (reset),
    .data        (line_data),
    .fall_strobe (fall_strobe),
    .frame       (frame),
    .frame_valid (frame_valid)
);

kbd_scan_decoder i_kbd_scan_decoder (
    .core_clk    (core_clk),
    .reset       (reset),
    .frame       (frame),
    .frame_valid (frame_valid),
    .key_event   (key_event),
    .event_valid (event_valid)
);

endmodule

// File: keyboard/kbd_scan_decoder.sv
`timescale 1ns/1ns
module kbd_scan_decoder
import kbd_pkg::*;
(
    input  logic       core_clk,
    input  logic       reset,
    input  kbd_frame_t frame,
    input  logic       frame_valid,
    output key_event_t key_event,
    output logic       event_valid
);

logic frame_bad;
logic is_ext;
logic is_release;
logic emit;
logic ext_flag;
logic release_flag;

assign frame_bad  = frame.parity_error | frame.framing_error;

// A corrupt byte is never taken as a prefix
assign is_ext     = !frame_bad && (frame.data == ext_prefix);
assign is_release = !frame_bad && (frame.data == release_prefix);
assign emit       = frame_valid && !is_ext && !is_release;

always_ff @(posedge core_clk) begin
    if (reset) begin
        ext_flag     <= 1'b0;
        release_flag <= 1'b0;
    end else if (frame_valid) begin
        if (is_ext) begin
            ext_flag <= 1'b1;
        end else if (is_release) begin
            release_flag <= 1'b1;
        end else begin
            ext_flag     <= 1'b0;     // Event consumes both prefixes
            release_flag <= 1'b0;
        end
    end
end

always_ff @(posedge core_clk) begin
    if (emit) begin
        key_event.code     <= frame.data;
        key_event.extended <= ext_flag;
        key_event.released <= release_flag;
        key_event.error    <= frame_bad;
    end
end

// One-cycle strobe, the core has no way to stall it
always_ff @(posedge core_clk) begin
    if (reset) begin
        event_valid <= 1'b0;
    end else begin
        event_valid <= emit;
    end
end

endmodule

// File: keyboard/kbd_frame_receiver.sv
`timescale 1ns/1ns
module kbd_frame_receiver
import kbd_pkg::*;
#(
    parameter int timeout_cycles = 2000
)(
    input  logic       core_clk,
    input  logic       reset,
    input  logic       data,
    input  logic       fall_strobe,
    output kbd_frame_t frame,
    output logic       frame_valid
);

localparam int idle_w = $clog2(timeout_cycles + 1);

logic [frame_bits-1:0] shift_q;
logic [frame_bits-1:0] shift_next;
logic [3:0]            bit_cnt;
logic [idle_w-1:0]     idle_cnt;
logic                  last_bit;
logic                  idle_expired;

// Wire order is LSB first, so new bits enter at the top
assign shift_next = {data, shift_q[frame_bits-1:1]};
assign last_bit   = fall_strobe && (bit_cnt == 4'(frame_bits - 1));

assign idle_expired = (bit_cnt != 4'd0) && !fall_strobe &&
                      (idle_cnt == idle_w'(timeout_cycles - 1));

always_ff @(posedge core_clk) begin
    if (fall_strobe) begin
        shift_q <= shift_next;
    end
end

always_ff @(posedge core_clk) begin
    if (reset) begin
        bit_cnt <= 4'd0;
    end else if (last_bit || idle_expired) begin
        bit_cnt <= 4'd0;             // Frame done or keyboard went quiet
    end else if (fall_strobe) begin
        bit_cnt <= bit_cnt + 4'd1;
    end
end

// Counts core cycles between falling edges of a partial frame
always_ff @(posedge core_clk) begin
    if (reset) begin
        idle_cnt <= '0;
    end else if (fall_strobe || bit_cnt == 4'd0 || idle_expired) begin
        idle_cnt <= '0;
    end else begin
        idle_cnt <= idle_cnt + 1'b1;
    end
end

// Checks run on the completed shift value, which includes the stop bit
always_ff @(posedge core_clk) begin
    if (last_bit) begin
        frame.data          <= shift_next[8:1];
        frame.parity_error  <= ~^shift_next[9:1];    // Needs odd count of ones
        frame.framing_error <= shift_next[0] | ~shift_next[10];
    end
end

always_ff @(posedge core_clk) begin
    if (reset) begin
        frame_valid <= 1'b0;
    end else begin
        frame_valid <= last_bit;
    end
end

endmodule

// File: logic/ps2_line_sync.sv
`timescale 1ns/1ns
module ps2_line_sync
import kbd_pkg::*;
#(
    parameter int sync_stages = 2,    // At least 2
    parameter int filter_len  = 4
)(
    input  logic       core_clk,
    input  logic       reset,
    input  ps2_lines_t ps2,
    output logic       data,
    output logic       fall_strobe
);

localparam int cnt_w = (filter_len > 1) ? $clog2(filter_len) : 1;

logic [1:0] line_raw;    // Bit 1 is clock, bit 0 is data
logic [1:0] line_filt;
logic       clk_prev;

assign line_raw = {ps2.clk, ps2.data};

for (genvar i = 0; i < 2; i++) begin : g_line
    logic [sync_stages-1:0] sync_q;
    logic [cnt_w-1:0]       stable_cnt;
    logic                   filt_q;
    logic                   line_diff;

    assign line_diff    = sync_q[sync_stages-1] ^ filt_q;
    assign line_filt[i] = filt_q;

    always_ff @(posedge core_clk) begin
        if (reset) begin
            sync_q     <= '1;      // Idle bus
            stable_cnt <= '0;
            filt_q     <= 1'b1;
        end else begin
            sync_q <= {sync_q[sync_stages-2:0], line_raw[i]};
            if (!line_diff) begin
                stable_cnt <= '0;  // Glitch ended early
            end else if (stable_cnt == cnt_w'(filter_len - 1)) begin
                filt_q     <= ~filt_q;
                stable_cnt <= '0;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end
end

// Keyboard drives data while its clock is high, so sample on the fall
always_ff @(posedge core_clk) begin
    if (reset) begin
        clk_prev    <= 1'b1;
        fall_strobe <= 1'b0;
    end else begin
        clk_prev    <= line_filt[1];
        fall_strobe <= clk_prev & ~line_filt[1];
    end
end

assign data = line_filt[0];

endmodule

// File: common/kbd_pkg.sv
package kbd_pkg;

    // Raw keyboard lines, both open collector and idle high
    typedef struct packed {
        logic clk;
        logic data;
    } ps2_lines_t;

    // One received 11-bit frame reduced to its payload and checks
    typedef struct packed {
        logic [7:0] data;           // Payload, LSB first on the wire
        logic       parity_error;   // Odd parity failed
        logic       framing_error;  // Start not 0 or stop not 1
    } kbd_frame_t;

    // One key action after prefix folding
    typedef struct packed {
        logic [7:0] code;           // Scan code without prefixes
        logic       extended;       // E0 seen before the code
        logic       released;       // F0 seen before the code
        logic       error;          // Frame carried a parity or framing error
    } key_event_t;

    // Scan code set 2 prefixes
    localparam logic [7:0] ext_prefix     = 8'hE0;
    localparam logic [7:0] release_prefix = 8'hF0;

    // Frame layout on the wire
    localparam int frame_bits = 11;   // Start, 8 data, parity, stop

endpackage
